/* sources.f */
gps_mon_cfg_pkg.sv
gps_mon_types_pkg.sv
mon_switch_decode.sv
corr_capture.sv
track_status.sv
display_format.sv
gps_mon_top.sv
tb_gps_mon.sv

/* run.sh */
#!/bin/sh
# Build the monitor testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

TOP=tb_gps_mon
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module "$TOP" -f sources.f -o "V$TOP"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./obj_dir/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
   exit 1
fi
exit 0

/* tb_gps_mon.sv */
module tb_gps_mon
   import gps_mon_cfg_pkg::*, gps_mon_types_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 8;
   localparam int T1_CYCLES    = 10;
   localparam int T2_PER_COMBO = 40;
   localparam int T3_PER_PAGE  = 150;
   localparam int T4_PER_HALF  = 40;
   localparam int T5_PER_HALF  = 40;
   localparam int TOTAL_CYCLES = RESET_CYCLES + T1_CYCLES + 6 * T2_PER_COMBO
                                 + 2 * T3_PER_PAGE + 2 * T4_PER_HALF + 2 * T5_PER_HALF;
   localparam int CYCLE_LIMIT  = TOTAL_CYCLES * 3 / 2;

   // Active-low hex font with bit 0 as segment a
   localparam logic [SEG_WIDTH-1:0] SEG_LUT [16] = '{
      7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
      7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
   };
   localparam logic [SEG_WIDTH-1:0] SEG_BLANK = '1;

   logic                          clk_200 = 1'b0;
   logic                          i_rst_n;
   logic [SW_WIDTH-1:0]           i_sw;
   logic                          i_acc_valid;
   acc_set_t                      i_acc;
   logic                          i_tracking_ready;
   logic [SAMPLE_COUNT_WIDTH-1:0] i_sample_count;
   pkt_stat_t                     i_pkt_stat;
   logic                          i_link_status;
   logic                          i_sample_valid;
   hex_word_t                     o_hex;
   logic [LEDR_WIDTH-1:0]         o_ledr;
   logic [LEDG_WIDTH-1:0]         o_ledg;

   // Reference model state
   logic [SW_WIDTH-1:0]           m_sw1;
   logic [SW_WIDTH-1:0]           m_sw2;
   disp_sel_t                     m_sel;
   acc_set_t                      m_acc;
   logic [UPDATE_COUNT_WIDTH-1:0] m_updates;
   logic [SC_HOLD_WIDTH-1:0]      m_sc;
   int                            m_ready_cnt;    // Cycles left in the LED window

   int seed;
   int cycles;
   int errors;
   int checks;
   int err_start;
   int chk_start;

   gps_mon_top u_dut (
      .clk_200          (clk_200),
      .i_rst_n          (i_rst_n),
      .i_sw             (i_sw),
      .i_acc_valid      (i_acc_valid),
      .i_acc            (i_acc),
      .i_tracking_ready (i_tracking_ready),
      .i_sample_count   (i_sample_count),
      .i_pkt_stat       (i_pkt_stat),
      .i_link_status    (i_link_status),
      .i_sample_valid   (i_sample_valid),
      .o_hex            (o_hex),
      .o_ledr           (o_ledr),
      .o_ledg           (o_ledg)
   );

   initial begin
      forever #(CLK_PERIOD / 2) clk_200 = ~clk_200;
   end

   always @(posedge clk_200) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: the run went past %0d clock cycles without finishing", CYCLE_LIMIT);
         $display("TEST FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] rnd();
      return $random(seed);
   endfunction

   function automatic disp_sel_t decode_sw(input logic [SW_WIDTH-1:0] sw);
      disp_sel_t s;
      s.q_not_i  = sw[SW_Q_I];
      s.pkt      = sw[SW_PKT];
      s.pkt_good = sw[SW_PKT_GOOD];
      if (sw[SW_COUNT]) begin
         s.page = PAGE_COUNT;
      end else if (sw[SW_UPDATE]) begin
         s.page = sw[SW_UPDATE_SC] ? PAGE_UPDATE_SC : PAGE_UPDATES;
      end else begin
         s.page = PAGE_CORR;
      end
      if (sw[SW_EL_P]) begin
         s.tap = sw[SW_E_L] ? EARLY : LATE;
      end else begin
         s.tap = PROMPT;
      end
      return s;
   endfunction

   // Mirrors one rising edge with the inputs seen at that edge
   task automatic model_step();
      if (!i_rst_n) begin
         m_sw1       = '0;
         m_sw2       = '0;
         m_sel       = decode_sw('0);
         m_acc       = '0;
         m_updates   = '0;
         m_sc        = '0;
         m_ready_cnt = 0;
      end else begin
         m_sel = decode_sw(m_sw2);          // Third stage of the switch path
         m_sw2 = m_sw1;
         m_sw1 = i_sw;
         if (i_acc_valid) begin
            m_acc = i_acc;
         end
         if (i_tracking_ready) begin
            m_updates   = m_updates + 1'b1;
            m_sc        = i_sample_count[SC_HOLD_WIDTH-1:0];
            m_ready_cnt = READY_HOLD_CYCLES + 1;
         end else if (m_ready_cnt > 0) begin
            m_ready_cnt--;
         end
      end
   endtask

   function automatic logic [ACC_WIDTH-1:0] exp_value();
      iq_t arm;
      case (m_sel.tap)
         EARLY:   arm = m_acc.early;
         LATE:    arm = m_acc.late;
         default: arm = m_acc.prompt;
      endcase
      return m_sel.q_not_i ? arm.q : arm.i;
   endfunction

   function automatic hex_word_t exp_hex();
      logic [31:0] word;
      int          lit;
      hex_word_t   h;
      lit = 5;
      case (m_sel.page)
         PAGE_COUNT: begin
            word = i_sample_count;
            lit  = 8;
         end
         PAGE_UPDATES:   word = {21'd0, m_updates};
         PAGE_UPDATE_SC: word = {8'd0, m_sc};
         default:        word = {13'd0, exp_value()};
      endcase
      for (int d = 0; d < NUM_DIGITS; d++) begin
         if (d < lit) begin
            h[d] = SEG_LUT[word[d*4 +: 4]];
         end else begin
            h[d] = SEG_BLANK;
         end
      end
      return h;
   endfunction

   function automatic logic [LEDR_WIDTH-1:0] exp_ledr();
      logic [ACC_WIDTH-1:0] v;
      v = exp_value();
      if (m_sel.pkt) begin
         return {9'd0, m_sel.pkt_good ? i_pkt_stat.good : i_pkt_stat.missed};
      end
      return v[LEDR_WIDTH-1:0];
   endfunction

   task automatic check_sig(input string name, input logic [63:0] exp, input logic [63:0] got);
      checks++;
      assert (exp == got) else begin
         $display("ERR %0t ns %s expected %h got %h", $time, name, exp, got);
         errors++;
      end
   endtask

   task automatic tick(input bit do_check);
      logic [LEDG_WIDTH-1:0] ledg;
      @(negedge clk_200);
      model_step();
      if (do_check) begin
         ledg = {i_link_status, 5'd0, m_ready_cnt > 0, i_sample_valid, 1'b0};
         check_sig("o_hex", 64'(exp_hex()), 64'(o_hex));
         check_sig("o_ledr", 64'(exp_ledr()), 64'(o_ledr));
         check_sig("o_ledg", 64'(ledg), 64'(o_ledg));
      end
   endtask

   task automatic drive_random(input logic [7:0] acc_thr, input logic [7:0] rdy_thr);
      logic [31:0]  r;
      logic [127:0] wide;
      r                = rnd();
      i_acc_valid      = r[7:0] < acc_thr;
      i_tracking_ready = r[15:8] < rdy_thr;
      i_link_status    = r[16];
      i_sample_valid   = r[17];
      i_sample_count   = rnd();
      r                = rnd();
      i_pkt_stat       = r[2*PKT_COUNT_WIDTH-1:0];
      wide             = {rnd(), rnd(), rnd(), rnd()};
      i_acc            = wide[$bits(acc_set_t)-1:0];
   endtask

   task automatic run_cycles(input int n, input logic [7:0] acc_thr, input logic [7:0] rdy_thr);
      repeat (n) begin
         tick(1'b1);
         drive_random(acc_thr, rdy_thr);
      end
   endtask

   function automatic logic [SW_WIDTH-1:0] sw_word(input logic q, input logic el_p,
                                                   input logic e_l, input logic pkt,
                                                   input logic good, input logic upd,
                                                   input logic upd_sc, input logic cnt);
      logic [SW_WIDTH-1:0] w;
      logic [31:0]         r;
      r               = rnd();
      w               = r[SW_WIDTH-1:0];    // Undecoded switches toggle freely
      w[SW_Q_I]       = q;
      w[SW_EL_P]      = el_p;
      w[SW_E_L]       = e_l;
      w[SW_PKT]       = pkt;
      w[SW_PKT_GOOD]  = good;
      w[SW_UPDATE]    = upd;
      w[SW_UPDATE_SC] = upd_sc;
      w[SW_COUNT]     = cnt;
      return w;
   endfunction

   task automatic start_test();
      err_start = errors;
      chk_start = checks;
   endtask

   task automatic end_test(input string name);
      $display("%s done: %0d checks, %0d errors", name, checks - chk_start, errors - err_start);
   endtask

   initial begin
      logic [31:0] r;
      seed             = 32'he0e7e5b8;
      cycles           = 0;
      errors           = 0;
      checks           = 0;
      i_rst_n          = 1'b0;
      i_sw             = '0;
      i_acc_valid      = 1'b0;
      i_acc            = '0;
      i_tracking_ready = 1'b0;
      i_sample_count   = '0;
      i_pkt_stat       = '0;
      i_link_status    = 1'b0;
      i_sample_valid   = 1'b0;

      repeat (RESET_CYCLES) tick(1'b0);
      i_rst_n = 1'b1;

      start_test();
      repeat (T1_CYCLES) tick(1'b1);
      check_sig("o_hex", 64'({{3{SEG_BLANK}}, {5{SEG_LUT[0]}}}), 64'(o_hex));
      end_test("Test 1 reset state");

      start_test();
      for (int c = 0; c < 6; c++) begin
         i_sw = sw_word(c[0], c >= 2, c >= 4, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
         run_cycles(T2_PER_COMBO, 8'd64, 8'd0);
      end
      end_test("Test 2 accumulation capture");

      start_test();
      for (int p = 0; p < 2; p++) begin
         r    = rnd();
         i_sw = sw_word(r[0], r[1], r[2], 1'b0, 1'b0, 1'b1, p[0], 1'b0);
         run_cycles(T3_PER_PAGE, 8'd32, 8'd16);   // Strobe gaps near the window length
      end
      end_test("Test 3 tracking updates");

      start_test();
      for (int h = 0; h < 2; h++) begin
         i_sw = sw_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, h[0], 1'b1, 1'b1);
         run_cycles(T4_PER_HALF, 8'd32, 8'd16);
      end
      end_test("Test 4 sample count page");

      start_test();
      for (int g = 0; g < 2; g++) begin
         r    = rnd();
         i_sw = sw_word(r[0], r[1], r[2], 1'b1, g[0], 1'b0, 1'b0, 1'b0);
         run_cycles(T5_PER_HALF, 8'd32, 8'd16);
      end
      end_test("Test 5 packet stats and status LEDs");

      $display("Summary: %0d checks, %0d errors, %0d cycles", checks, errors, cycles);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* gps_mon_top.sv */
module gps_mon_top
   import gps_mon_cfg_pkg::*, gps_mon_types_pkg::*;
(
   input  logic                          clk_200,
   input  logic                          i_rst_n,
   input  logic [SW_WIDTH-1:0]           i_sw,
   input  logic                          i_acc_valid,
   input  acc_set_t                      i_acc,
   input  logic                          i_tracking_ready,
   input  logic [SAMPLE_COUNT_WIDTH-1:0] i_sample_count,
   input  pkt_stat_t                     i_pkt_stat,
   input  logic                          i_link_status,
   input  logic                          i_sample_valid,
   output hex_word_t                     o_hex,
   output logic [LEDR_WIDTH-1:0]         o_ledr,
   output logic [LEDG_WIDTH-1:0]         o_ledg
);

   disp_sel_t                     sel;
   logic [ACC_WIDTH-1:0]          acc_value;
   logic [UPDATE_COUNT_WIDTH-1:0] updates;
   logic [SC_HOLD_WIDTH-1:0]      sc_hold;
   logic                          ready_flag;

   mon_switch_decode u_decode (
      .clk_200 (clk_200),
      .i_rst_n (i_rst_n),
      .i_sw    (i_sw),
      .o_sel   (sel)
   );

   corr_capture u_corr (
      .clk_200     (clk_200),
      .i_rst_n     (i_rst_n),
      .i_acc_valid (i_acc_valid),
      .i_acc       (i_acc),
      .i_sel       (sel),
      .o_value     (acc_value)
   );

   track_status u_status (
      .clk_200          (clk_200),
      .i_rst_n          (i_rst_n),
      .i_tracking_ready (i_tracking_ready),
      .i_sample_count   (i_sample_count),
      .o_updates        (updates),
      .o_sc_hold        (sc_hold),
      .o_ready_flag     (ready_flag)
   );

   display_format u_format (
      .i_sel          (sel),
      .i_value        (acc_value),
      .i_updates      (updates),
      .i_sc_hold      (sc_hold),
      .i_sample_count (i_sample_count),
      .i_pkt_stat     (i_pkt_stat),
      .i_link_status  (i_link_status),
      .i_sample_valid (i_sample_valid),
      .i_ready_flag   (ready_flag),
      .o_hex          (o_hex),
      .o_ledr         (o_ledr),
      .o_ledg         (o_ledg)
   );

endmodule

/* display_format.sv */
module display_format
   import gps_mon_cfg_pkg::*, gps_mon_types_pkg::*;
(
   input  disp_sel_t                     i_sel,
   input  logic [ACC_WIDTH-1:0]          i_value,
   input  logic [UPDATE_COUNT_WIDTH-1:0] i_updates,
   input  logic [SC_HOLD_WIDTH-1:0]      i_sc_hold,
   input  logic [SAMPLE_COUNT_WIDTH-1:0] i_sample_count,
   input  pkt_stat_t                     i_pkt_stat,
   input  logic                          i_link_status,
   input  logic                          i_sample_valid,
   input  logic                          i_ready_flag,
   output hex_word_t                     o_hex,
   output logic [LEDR_WIDTH-1:0]         o_ledr,
   output logic [LEDG_WIDTH-1:0]         o_ledg
);

   logic [DISP_WIDTH-1:0] disp_word;
   logic [NUM_DIGITS-1:0] digit_on;

   // Active-low segments, bit 0 is segment a
   function automatic logic [SEG_WIDTH-1:0] seg_encode(input logic [NIBBLE_WIDTH-1:0] nib);
      logic [SEG_WIDTH-1:0] seg;
      case (nib)
         4'h0:    seg = 7'h40;
         4'h1:    seg = 7'h79;
         4'h2:    seg = 7'h24;
         4'h3:    seg = 7'h30;
         4'h4:    seg = 7'h19;
         4'h5:    seg = 7'h12;
         4'h6:    seg = 7'h02;
         4'h7:    seg = 7'h78;
         4'h8:    seg = 7'h00;
         4'h9:    seg = 7'h10;
         4'ha:    seg = 7'h08;
         4'hb:    seg = 7'h03;
         4'hc:    seg = 7'h46;
         4'hd:    seg = 7'h21;
         4'he:    seg = 7'h06;
         default: seg = 7'h0e;
      endcase
      return seg;
   endfunction

   // Pick the word behind the digits
   always_comb begin
      case (i_sel.page)
         PAGE_COUNT:     disp_word = DISP_WIDTH'(i_sample_count);
         PAGE_UPDATES:   disp_word = DISP_WIDTH'(i_updates);
         PAGE_UPDATE_SC: disp_word = DISP_WIDTH'(i_sc_hold);
         default:        disp_word = DISP_WIDTH'(i_value);   // Top bits land on digit 4
      endcase
   end

   // Only the count page lights the upper digits
   always_comb begin
      for (int d = 0; d < NUM_DIGITS; d++) begin
         digit_on[d] = (i_sel.page == PAGE_COUNT) || (d < LOW_PAGE_DIGITS);
      end
   end

   always_comb begin
      for (int d = 0; d < NUM_DIGITS; d++) begin
         if (digit_on[d]) begin
            o_hex[d] = seg_encode(disp_word[d*NIBBLE_WIDTH +: NIBBLE_WIDTH]);
         end else begin
            o_hex[d] = '1;                   // Blank
         end
      end
   end

   always_comb begin
      if (i_sel.pkt) begin
         o_ledr = i_sel.pkt_good ? LEDR_WIDTH'(i_pkt_stat.good)
                                 : LEDR_WIDTH'(i_pkt_stat.missed);
      end else begin
         o_ledr = i_value[LEDR_WIDTH-1:0];
      end
   end

   always_comb begin
      o_ledg                 = '0;
      o_ledg[LEDG_LINK_BIT]  = i_link_status;
      o_ledg[LEDG_READY_BIT] = i_ready_flag;
      o_ledg[LEDG_VALID_BIT] = i_sample_valid;
   end

endmodule

/* track_status.sv */
module track_status
   import gps_mon_cfg_pkg::*;
(
   input  logic                          clk_200,
   input  logic                          i_rst_n,
   input  logic                          i_tracking_ready,
   input  logic [SAMPLE_COUNT_WIDTH-1:0] i_sample_count,
   output logic [UPDATE_COUNT_WIDTH-1:0] o_updates,
   output logic [SC_HOLD_WIDTH-1:0]      o_sc_hold,
   output logic                          o_ready_flag
);

   logic [READY_CNT_WIDTH-1:0] hold_cnt;

   // Counter wraps at its width
   always_ff @(posedge clk_200 or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_updates <= '0;
         o_sc_hold <= '0;
      end else if (i_tracking_ready) begin
         o_updates <= o_updates + 1'b1;
         o_sc_hold <= i_sample_count[SC_HOLD_WIDTH-1:0];
      end
   end

   // A new strobe reloads the count and restarts the window
   always_ff @(posedge clk_200 or negedge i_rst_n) begin
      if (!i_rst_n) begin
         hold_cnt     <= '0;
         o_ready_flag <= 1'b0;
      end else if (i_tracking_ready) begin
         hold_cnt     <= READY_CNT_WIDTH'(READY_HOLD_CYCLES);
         o_ready_flag <= 1'b1;
      end else if (hold_cnt == '0) begin
         o_ready_flag <= 1'b0;               // Window over
      end else begin
         hold_cnt <= hold_cnt - 1'b1;
      end
   end

endmodule

/* corr_capture.sv */
module corr_capture
   import gps_mon_cfg_pkg::*, gps_mon_types_pkg::*;
(
   input  logic                 clk_200,
   input  logic                 i_rst_n,
   input  logic                 i_acc_valid,
   input  acc_set_t             i_acc,
   input  disp_sel_t            i_sel,
   output logic [ACC_WIDTH-1:0] o_value
);

   acc_set_t acc_q;
   iq_t      tap_iq;

   // Whole set is replaced on each strobe
   always_ff @(posedge clk_200 or negedge i_rst_n) begin
      if (!i_rst_n) begin
         acc_q <= '0;
      end else if (i_acc_valid) begin
         acc_q <= i_acc;
      end
   end

   always_comb begin
      case (i_sel.tap)
         EARLY:   tap_iq = acc_q.early;
         LATE:    tap_iq = acc_q.late;
         default: tap_iq = acc_q.prompt;
      endcase
   end

   assign o_value = i_sel.q_not_i ? tap_iq.q : tap_iq.i;

endmodule

/* mon_switch_decode.sv */
module mon_switch_decode
   import gps_mon_cfg_pkg::*, gps_mon_types_pkg::*;
(
   input  logic                clk_200,
   input  logic                i_rst_n,
   input  logic [SW_WIDTH-1:0] i_sw,
   output disp_sel_t           o_sel
);

   logic [SW_WIDTH-1:0] sw_meta;
   logic [SW_WIDTH-1:0] sw_sync;
   disp_sel_t           sel_d;

   // Switches bounce in from the board, two flops before use
   always_ff @(posedge clk_200 or negedge i_rst_n) begin
      if (!i_rst_n) begin
         sw_meta <= '0;
         sw_sync <= '0;
      end else begin
         sw_meta <= i_sw;
         sw_sync <= sw_meta;
      end
   end

   always_comb begin
      sel_d = SEL_RESET;

      if (sw_sync[SW_COUNT]) begin
         sel_d.page = PAGE_COUNT;            // Count wins over update
      end else if (sw_sync[SW_UPDATE]) begin
         sel_d.page = sw_sync[SW_UPDATE_SC] ? PAGE_UPDATE_SC : PAGE_UPDATES;
      end else begin
         sel_d.page = PAGE_CORR;
      end

      if (sw_sync[SW_EL_P] && sw_sync[SW_E_L]) begin
         sel_d.tap = EARLY;
      end else if (sw_sync[SW_EL_P]) begin
         sel_d.tap = LATE;
      end else begin
         sel_d.tap = PROMPT;
      end

      sel_d.q_not_i  = sw_sync[SW_Q_I];
      sel_d.pkt      = sw_sync[SW_PKT];
      sel_d.pkt_good = sw_sync[SW_PKT_GOOD];
   end

   always_ff @(posedge clk_200 or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_sel <= SEL_RESET;
      end else begin
         o_sel <= sel_d;
      end
   end

endmodule

/* gps_mon_types_pkg.sv */
package gps_mon_types_pkg;

   import gps_mon_cfg_pkg::*;

   // One correlator arm
   typedef struct packed {
      logic [ACC_WIDTH-1:0] i;
      logic [ACC_WIDTH-1:0] q;
   } iq_t;

   // Full accumulation set from the tracking channel
   typedef struct packed {
      iq_t early;
      iq_t prompt;
      iq_t late;
   } acc_set_t;

   // Ethernet feed statistics
   typedef struct packed {
      logic [PKT_COUNT_WIDTH-1:0] good;
      logic [PKT_COUNT_WIDTH-1:0] missed;
   } pkt_stat_t;

   typedef enum logic [1:0] {
      PAGE_CORR,
      PAGE_COUNT,
      PAGE_UPDATES,
      PAGE_UPDATE_SC
   } page_e;

   typedef enum logic [1:0] {
      EARLY,
      PROMPT,
      LATE
   } tap_e;

   typedef struct packed {
      page_e page;
      tap_e  tap;
      logic  q_not_i;    // Quadrature arm shown
      logic  pkt;        // Packet stats on red LEDs
      logic  pkt_good;   // Good count, else missed
   } disp_sel_t;

   localparam disp_sel_t SEL_RESET = '{page: PAGE_CORR, tap: PROMPT, q_not_i: 1'b0,
                                       pkt: 1'b0, pkt_good: 1'b0};

   // Digit 0 sits in the low slice
   typedef logic [NUM_DIGITS-1:0][SEG_WIDTH-1:0] hex_word_t;

endpackage

/* gps_mon_cfg_pkg.sv */
package gps_mon_cfg_pkg;

   // Correlator and counter widths
   localparam int ACC_WIDTH          = 19;
   localparam int SAMPLE_COUNT_WIDTH = 32;
   localparam int SC_HOLD_WIDTH      = 24;
   localparam int UPDATE_COUNT_WIDTH = 11;
   localparam int PKT_COUNT_WIDTH    = 9;

   // Ready LED stretch, extra cycles after the strobe
   localparam int READY_HOLD_CYCLES = 15;
   localparam int READY_CNT_WIDTH   = $clog2(READY_HOLD_CYCLES + 1);

   // Board display resources
   localparam int NUM_DIGITS      = 8;
   localparam int SEG_WIDTH       = 7;
   localparam int NIBBLE_WIDTH    = 4;
   localparam int DISP_WIDTH      = NUM_DIGITS * NIBBLE_WIDTH;
   localparam int LOW_PAGE_DIGITS = 5;    // Digits lit on the short pages
   localparam int LEDR_WIDTH      = 18;
   localparam int LEDG_WIDTH      = 9;
   localparam int SW_WIDTH        = 18;

   // Green LED bit positions
   localparam int LEDG_LINK_BIT  = 8;
   localparam int LEDG_READY_BIT = 2;
   localparam int LEDG_VALID_BIT = 1;

   // Switch bit positions
   localparam int SW_Q_I        = 17;
   localparam int SW_EL_P       = 16;
   localparam int SW_E_L        = 15;
   localparam int SW_PKT        = 11;
   localparam int SW_PKT_GOOD   = 10;
   localparam int SW_UPDATE     = 6;
   localparam int SW_UPDATE_SC  = 5;
   localparam int SW_COUNT      = 4;

endpackage
